/* Bender.yml */
package:
  name: load_store_unit

sources:
  - lsu_pkg.sv
  - lsu_agu.sv
  - lsu_misalign_check.sv
  - lsu_bypass.sv
  - load_unit.sv
  - store_unit.sv
  - load_store_unit.sv
  - target: test
    files:
      - tb_data_mem.sv
      - tb_load_store_unit.sv

/* files.f */
lsu_pkg.sv
lsu_agu.sv
lsu_misalign_check.sv
lsu_bypass.sv
load_unit.sv
store_unit.sv
load_store_unit.sv
tb_data_mem.sv
tb_load_store_unit.sv

/* load_store_unit.sv */
module load_store_unit #(
    parameter int unsigned NrBypassEntries = 2
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  logic                 lsu_valid_i,
    input  lsu_pkg::fu_data_t    fu_data_i,
    output logic                 lsu_ready_o,
    output lsu_pkg::lsu_result_t load_result_o,
    output lsu_pkg::lsu_result_t store_result_o,
    output lsu_pkg::dmem_req_t   ld_mem_req_o,
    output lsu_pkg::dmem_req_t   st_mem_req_o,
    input  lsu_pkg::dmem_resp_t  ld_mem_resp_i,
    input  lsu_pkg::dmem_resp_t  st_mem_resp_i
);
    import lsu_pkg::*;

    lsu_ctrl_t      lsu_req;
    lsu_ctrl_t      lsu_ctrl;
    logic           pop_ld;
    logic           pop_st;
    logic           ld_valid;
    logic           st_valid;
    logic           misaligned;
    lsu_exception_t misaligned_ex;

    lsu_agu u_lsu_agu (
        .fu_data_i   (fu_data_i),
        .lsu_valid_i (lsu_valid_i),
        .lsu_req_o   (lsu_req)
    );

    lsu_bypass #(
        .NrBypassEntries (NrBypassEntries)
    ) u_lsu_bypass (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .lsu_req_i       (lsu_req),
        .lsu_req_valid_i (lsu_valid_i),
        .pop_ld_i        (pop_ld),
        .pop_st_i        (pop_st),
        .lsu_ctrl_o      (lsu_ctrl),
        .ready_o         (lsu_ready_o)
    );

    lsu_misalign_check u_lsu_misalign_check (
        .lsu_ctrl_i      (lsu_ctrl),
        .misaligned_o    (misaligned),
        .misaligned_ex_o (misaligned_ex)
    );

    // ------------------------------------------------------------------
    // dispatch by operation kind
    // ------------------------------------------------------------------
    always_comb begin
        ld_valid = 1'b0;
        st_valid = 1'b0;
        if (lsu_ctrl.valid) begin
            if (is_load(lsu_ctrl.operator)) begin
                ld_valid = 1'b1;
            end else begin
                st_valid = 1'b1;
            end
        end
    end

    load_unit u_load_unit (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .valid_i         (ld_valid),
        .lsu_ctrl_i      (lsu_ctrl),
        .misaligned_i    (misaligned),
        .misaligned_ex_i (misaligned_ex),
        .pop_ld_o        (pop_ld),
        .ld_mem_req_o    (ld_mem_req_o),
        .ld_mem_resp_i   (ld_mem_resp_i),
        .load_result_o   (load_result_o)
    );

    store_unit u_store_unit (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .valid_i         (st_valid),
        .lsu_ctrl_i      (lsu_ctrl),
        .misaligned_i    (misaligned),
        .misaligned_ex_i (misaligned_ex),
        .pop_st_o        (pop_st),
        .st_mem_req_o    (st_mem_req_o),
        .st_mem_resp_i   (st_mem_resp_i),
        .store_result_o  (store_result_o)
    );

endmodule

/* load_unit.sv */
module load_unit (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  lsu_pkg::lsu_ctrl_t      lsu_ctrl_i,
    input  logic                    misaligned_i,
    input  lsu_pkg::lsu_exception_t misaligned_ex_i,
    output logic                    pop_ld_o,
    output lsu_pkg::dmem_req_t      ld_mem_req_o,
    input  lsu_pkg::dmem_resp_t     ld_mem_resp_i,
    output lsu_pkg::lsu_result_t    load_result_o
);
    import lsu_pkg::*;

    typedef enum logic {IDLE, WAIT_RVALID} state_e;

    state_e                   state_q;
    logic                     drop_q;
    logic [TRANS_ID_BITS-1:0] id_q;
    logic [1:0]               offset_q;
    lsu_op_t                  op_q;
    logic                     issue;
    logic                     accept;
    logic [XLEN-1:0]          shifted;
    logic [XLEN-1:0]          extracted;

    // one read outstanding at most
    assign issue  = valid_i && !misaligned_i && (state_q == IDLE);
    assign accept = issue && ld_mem_resp_i.gnt;

    assign ld_mem_req_o = '{
        req:   issue,
        addr:  {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00},
        we:    1'b0,
        be:    lsu_ctrl_i.be,
        wdata: '0
    };

    assign pop_ld_o = accept || (valid_i && misaligned_i && (state_q == IDLE));

    // ------------------------------------------------------------------
    // lane select and extension
    // ------------------------------------------------------------------
    assign shifted = ld_mem_resp_i.rdata >> {offset_q, 3'b000};

    always_comb begin
        case (op_q)
            LB:      extracted = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     extracted = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:      extracted = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     extracted = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: extracted = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_q     <= lsu_ctrl_i.trans_id;
            offset_q <= lsu_ctrl_i.vaddr[1:0];
            op_q     <= lsu_ctrl_i.operator;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= IDLE;
            drop_q        <= 1'b0;
            load_result_o <= '0;
        end else begin
            load_result_o.valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= WAIT_RVALID;
                        drop_q  <= flush_i;
                    end else if (valid_i && misaligned_i) begin
                        load_result_o <= '{valid: 1'b1, trans_id: lsu_ctrl_i.trans_id,
                                           result: '0, ex: misaligned_ex_i};
                    end
                end
                default: begin
                    if (ld_mem_resp_i.rvalid) begin
                        state_q <= IDLE;
                        drop_q  <= 1'b0;
                        // flushed reads still return, the data is just thrown away
                        if (!drop_q && !flush_i) begin
                            load_result_o <= '{valid: 1'b1, trans_id: id_q,
                                               result: extracted, ex: '0};
                        end
                    end else if (flush_i) begin
                        drop_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ld_mem_resp_i.rvalid |-> state_q == WAIT_RVALID)
        else $error("read response without an outstanding load");

endmodule

/* lsu_agu.sv */
module lsu_agu (
    input  lsu_pkg::fu_data_t  fu_data_i,
    input  logic               lsu_valid_i,
    output lsu_pkg::lsu_ctrl_t lsu_req_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0]    vaddr;
    logic [1:0]         offset;
    logic [BE_BITS-1:0] be;
    logic [XLEN-1:0]    lane_data;

    // immediate is sign interpreted, no translation behind this
    assign vaddr  = $unsigned($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));
    assign offset = vaddr[1:0];

    // ------------------------------------------------------------------
    // byte enables
    // ------------------------------------------------------------------
    always_comb begin
        case (size_of(fu_data_i.operator))
            SIZE_BYTE: be = BE_BITS'(1) << offset;
            SIZE_HALF: be = BE_BITS'(3) << offset;
            default:   be = '1;
        endcase
    end

    // store data moved into its byte lane
    assign lane_data = fu_data_i.operand_b << {offset, 3'b000};

    assign lsu_req_o = '{
        valid:    lsu_valid_i,
        vaddr:    vaddr,
        data:     lane_data,
        be:       be,
        operator: fu_data_i.operator,
        trans_id: fu_data_i.trans_id
    };

endmodule

/* lsu_bypass.sv */
module lsu_bypass #(
    parameter int unsigned NrBypassEntries = 2
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  lsu_pkg::lsu_ctrl_t lsu_req_i,
    input  logic               lsu_req_valid_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
    output logic               ready_o
);
    import lsu_pkg::*;

    localparam int unsigned PtrBits = $clog2(NrBypassEntries);

    lsu_ctrl_t [NrBypassEntries-1:0] mem_q;
    logic [PtrBits-1:0]              rd_ptr_q;
    logic [PtrBits-1:0]              wr_ptr_q;
    logic [PtrBits:0]                count_q;
    logic                            empty;
    logic                            pop;

    assign empty   = (count_q == '0);
    assign pop     = pop_ld_i | pop_st_i;
    assign ready_o = empty;

    // incoming word is presented directly while nothing is queued
    assign lsu_ctrl_o = empty ? lsu_req_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (lsu_req_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({lsu_req_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // pass-through pushes write the entry and clear its valid in the same cycle
    always_ff @(posedge clk_i) begin
        if (lsu_req_valid_i) begin
            mem_q[wr_ptr_q] <= lsu_req_i;
        end
        if (pop) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        lsu_req_valid_i |-> count_q < NrBypassEntries)
        else $error("push into full bypass queue");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop |-> !empty || lsu_req_valid_i)
        else $error("pop from empty bypass queue");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(pop_ld_i && pop_st_i))
        else $error("load and store unit popped together");

endmodule

/* lsu_misalign_check.sv */
module lsu_misalign_check (
    input  lsu_pkg::lsu_ctrl_t      lsu_ctrl_i,
    output logic                    misaligned_o,
    output lsu_pkg::lsu_exception_t misaligned_ex_o
);
    import lsu_pkg::*;

    // bytes are always aligned
    always_comb begin
        misaligned_o = 1'b0;
        if (lsu_ctrl_i.valid) begin
            case (size_of(lsu_ctrl_i.operator))
                SIZE_WORD: misaligned_o = (lsu_ctrl_i.vaddr[1:0] != 2'b00);
                SIZE_HALF: misaligned_o = lsu_ctrl_i.vaddr[0];
                default:   misaligned_o = 1'b0;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // exception word
    // ------------------------------------------------------------------
    always_comb begin
        misaligned_ex_o = '0;
        if (misaligned_o) begin
            if (is_load(lsu_ctrl_i.operator)) begin
                misaligned_ex_o.cause = LD_ADDR_MISALIGNED;
            end else begin
                misaligned_ex_o.cause = ST_ADDR_MISALIGNED;
            end
            // faulting address goes to tval
            misaligned_ex_o.tval  = lsu_ctrl_i.vaddr;
            misaligned_ex_o.valid = 1'b1;
        end
    end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned BE_BITS       = XLEN / 8;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } lsu_op_t;

    // access size derived from the operator
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } lsu_size_t;

    // trap causes
    localparam logic [XLEN-1:0] LD_ADDR_MISALIGNED = XLEN'(4);
    localparam logic [XLEN-1:0] ST_ADDR_MISALIGNED = XLEN'(6);

    // ------------------------------------------------------------------
    // request and result words
    // ------------------------------------------------------------------
    typedef struct packed {
        lsu_op_t                  operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          data;
        logic [BE_BITS-1:0]       be;
        lsu_op_t                  operator;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;
        logic            valid;
    } lsu_exception_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        lsu_exception_t           ex;
    } lsu_result_t;

    // ------------------------------------------------------------------
    // memory port
    // ------------------------------------------------------------------
    typedef struct packed {
        logic               req;
        logic [XLEN-1:0]    addr;
        logic               we;
        logic [BE_BITS-1:0] be;
        logic [XLEN-1:0]    wdata;
    } dmem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
    } dmem_resp_t;

    function automatic logic is_load(lsu_op_t op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic lsu_size_t size_of(lsu_op_t op);
        case (op)
            LB, LBU, SB: return SIZE_BYTE;
            LH, LHU, SH: return SIZE_HALF;
            default:     return SIZE_WORD;
        endcase
    endfunction

endpackage

/* store_unit.sv */
module store_unit (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    valid_i,
    input  lsu_pkg::lsu_ctrl_t      lsu_ctrl_i,
    input  logic                    misaligned_i,
    input  lsu_pkg::lsu_exception_t misaligned_ex_i,
    output logic                    pop_st_o,
    output lsu_pkg::dmem_req_t      st_mem_req_o,
    input  lsu_pkg::dmem_resp_t     st_mem_resp_i,
    output lsu_pkg::lsu_result_t    store_result_o
);
    import lsu_pkg::*;

    logic issue;

    assign issue = valid_i && !misaligned_i;

    // memory is written at grant
    assign st_mem_req_o = '{
        req:   issue,
        addr:  {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00},
        we:    1'b1,
        be:    lsu_ctrl_i.be,
        wdata: lsu_ctrl_i.data
    };

    assign pop_st_o = valid_i && (misaligned_i || st_mem_resp_i.gnt);

    // exception word is all zero unless the access was misaligned
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            store_result_o <= '0;
        end else begin
            store_result_o.valid <= 1'b0;
            if (pop_st_o) begin
                store_result_o <= '{valid: 1'b1, trans_id: lsu_ctrl_i.trans_id,
                                    result: '0, ex: misaligned_ex_i};
            end
        end
    end

endmodule

/* tb_data_mem.sv */
module tb_data_mem #(
    parameter logic [31:0] Seed = 32'h1f09e496
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                long_stall_i,
    input  lsu_pkg::dmem_req_t  ld_req_i,
    output lsu_pkg::dmem_resp_t ld_resp_o,
    input  lsu_pkg::dmem_req_t  st_req_i,
    output lsu_pkg::dmem_resp_t st_resp_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int unsigned Words     = 256;
    localparam int unsigned LongStall = 6;

    logic [XLEN-1:0] mem [Words];
    logic [31:0]     lfsr_q;
    logic [1:0]      ld_stall_q;
    logic [1:0]      st_stall_q;
    logic [3:0]      ld_cnt_q;
    logic [3:0]      st_cnt_q;
    logic            ld_rvalid_q;
    logic [XLEN-1:0] ld_rdata_q;
    logic [3:0]      extra;
    logic            ld_gnt;
    logic            st_gnt;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits taken, one step for each
    function automatic logic [1:0] draw_stall(inout logic [31:0] s);
        logic [1:0] v;
        for (int k = 0; k < 2; k++) begin
            v[k] = s[0];
            s    = lfsr_step(s);
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] fill_word(int unsigned idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'h5a, ~a, a, a ^ 8'hc3};
    endfunction

    // ------------------------------------------------------------------
    // grant after 0 to 3 stall cycles, plus a fixed extra when asked
    // ------------------------------------------------------------------
    assign extra  = long_stall_i ? 4'(LongStall) : 4'd0;
    assign ld_gnt = ld_req_i.req && (ld_cnt_q >= {2'b00, ld_stall_q} + extra);
    assign st_gnt = st_req_i.req && (st_cnt_q >= {2'b00, st_stall_q} + extra);

    assign ld_resp_o = '{gnt: ld_gnt, rvalid: ld_rvalid_q, rdata: ld_rdata_q};
    assign st_resp_o = '{gnt: st_gnt, rvalid: 1'b0, rdata: '0};

    always @(posedge clk_i or negedge arst_n_i) begin : update
        logic [31:0] s;
        s = lfsr_q;
        if (!arst_n_i) begin
            lfsr_q      <= Seed;
            ld_stall_q  <= '0;
            st_stall_q  <= '0;
            ld_cnt_q    <= '0;
            st_cnt_q    <= '0;
            ld_rvalid_q <= 1'b0;
            ld_rdata_q  <= '0;
            for (int i = 0; i < Words; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            // read data comes back one cycle after grant
            ld_rvalid_q <= ld_gnt && !ld_req_i.we;
            if (ld_gnt) begin
                ld_rdata_q <= mem[ld_req_i.addr[9:2]];
                ld_stall_q <= draw_stall(s);
                ld_cnt_q   <= '0;
            end else if (ld_req_i.req) begin
                ld_cnt_q <= ld_cnt_q + 1'b1;
            end
            if (st_gnt) begin
                for (int b = 0; b < BE_BITS; b++) begin
                    if (st_req_i.we && st_req_i.be[b]) begin
                        mem[st_req_i.addr[9:2]][8*b +: 8] <= st_req_i.wdata[8*b +: 8];
                    end
                end
                st_stall_q <= draw_stall(s);
                st_cnt_q   <= '0;
            end else if (st_req_i.req) begin
                st_cnt_q <= st_cnt_q + 1'b1;
            end
            lfsr_q <= s;
        end
    end

endmodule

/* tb_load_store_unit.sv */
module tb_load_store_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int unsigned NrBypassEntries = 2;
    localparam logic [31:0] LfsrSeed        = 32'h1f09e496;
    localparam int unsigned ResetCycles     = 8;
    // operations issued over all tests, 40 cycles allowed for each
    localparam int unsigned NumOps          = 28;
    localparam int unsigned MaxCycles       = 40 * NumOps + ResetCycles;

    logic        clk_i;
    logic        arst_n_i;
    logic        flush_i;
    logic        lsu_valid_i;
    fu_data_t    fu_data_i;
    logic        lsu_ready_o;
    lsu_result_t load_result_o;
    lsu_result_t store_result_o;
    dmem_req_t   ld_mem_req_o;
    dmem_req_t   st_mem_req_o;
    dmem_resp_t  ld_mem_resp_i;
    dmem_resp_t  st_mem_resp_i;
    logic        long_stall;

    logic [XLEN-1:0] shadow [256];
    lsu_result_t     ld_results[$];
    lsu_result_t     st_results[$];
    logic            mem_req_seen;

    load_store_unit #(
        .NrBypassEntries (NrBypassEntries)
    ) u_load_store_unit (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .lsu_valid_i    (lsu_valid_i),
        .fu_data_i      (fu_data_i),
        .lsu_ready_o    (lsu_ready_o),
        .load_result_o  (load_result_o),
        .store_result_o (store_result_o),
        .ld_mem_req_o   (ld_mem_req_o),
        .st_mem_req_o   (st_mem_req_o),
        .ld_mem_resp_i  (ld_mem_resp_i),
        .st_mem_resp_i  (st_mem_resp_i)
    );

    tb_data_mem #(
        .Seed (LfsrSeed)
    ) u_data_mem (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .long_stall_i (long_stall),
        .ld_req_i     (ld_mem_req_o),
        .ld_resp_o    (ld_mem_resp_i),
        .st_req_i     (st_mem_req_o),
        .st_resp_o    (st_mem_resp_i)
    );

    always #50 clk_i = ~clk_i;

    // results are registered, so the falling edge sees them stable
    always @(negedge clk_i) begin
        if (load_result_o.valid) begin
            ld_results.push_back(load_result_o);
        end
        if (store_result_o.valid) begin
            st_results.push_back(store_result_o);
        end
    end

    always @(posedge clk_i) begin
        if (ld_mem_req_o.req || st_mem_req_o.req) begin
            mem_req_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_result(string what, lsu_result_t got, lsu_result_t exp);
        if (got.valid !== exp.valid || got.trans_id !== exp.trans_id
                || got.result !== exp.result) begin
            $display("[FAIL] %0t: %s got id %0d data %h, expected id %0d data %h",
                     $time, what, got.trans_id, got.result, exp.trans_id, exp.result);
            abort_run();
        end
    endtask

    task automatic check_exception(string what, lsu_exception_t got, lsu_exception_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got cause %0d tval %h valid %b, expected %0d %h %b",
                     $time, what, got.cause, got.tval, got.valid,
                     exp.cause, exp.tval, exp.valid);
            abort_run();
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------
    // reference model and drivers
    // ------------------------------------------------------------------
    task automatic shadow_store(lsu_op_t op, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
        int nbytes;
        nbytes = (op == SB) ? 1 : ((op == SH) ? 2 : 4);
        for (int b = 0; b < nbytes; b++) begin
            shadow[addr[9:2]][8*(addr[1:0] + b) +: 8] = data[8*b +: 8];
        end
    endtask

    function automatic logic [XLEN-1:0] expect_load(lsu_op_t op, logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        logic [7:0]      byte_val;
        logic [15:0]     half_val;
        word     = shadow[addr[9:2]] >> (8 * addr[1:0]);
        byte_val = word[7:0];
        half_val = word[15:0];
        case (op)
            LB:      return {{24{byte_val[7]}}, byte_val};
            LBU:     return {24'b0, byte_val};
            LH:      return {{16{half_val[15]}}, half_val};
            LHU:     return {16'b0, half_val};
            default: return shadow[addr[9:2]];
        endcase
    endfunction

    // called on a falling edge, returns one falling edge after the push
    task automatic issue_op(lsu_op_t op, logic [XLEN-1:0] base, logic [XLEN-1:0] imm,
                            logic [XLEN-1:0] data, logic [TRANS_ID_BITS-1:0] id);
        while (!lsu_ready_o) begin
            @(negedge clk_i);
        end
        lsu_valid_i = 1'b1;
        fu_data_i   = '{operator: op, operand_a: base, operand_b: data, imm: imm,
                        trans_id: id};
        @(negedge clk_i);
        lsu_valid_i = 1'b0;
    endtask

    task automatic take_result(logic from_load, output lsu_result_t res);
        if (from_load) begin
            while (ld_results.size() == 0) begin
                @(negedge clk_i);
            end
            res = ld_results.pop_front();
        end else begin
            while (st_results.size() == 0) begin
                @(negedge clk_i);
            end
            res = st_results.pop_front();
        end
    endtask

    task automatic do_store(lsu_op_t op, logic [XLEN-1:0] base, logic [XLEN-1:0] imm,
                            logic [XLEN-1:0] data, logic [TRANS_ID_BITS-1:0] id);
        lsu_result_t res;
        issue_op(op, base, imm, data, id);
        take_result(1'b0, res);
        check_result("store", res, '{valid: 1'b1, trans_id: id, result: '0, ex: '0});
        check_exception("store", res.ex, '0);
        shadow_store(op, base + imm, data);
    endtask

    task automatic do_load(lsu_op_t op, logic [XLEN-1:0] base, logic [XLEN-1:0] imm,
                           logic [TRANS_ID_BITS-1:0] id);
        lsu_result_t res;
        lsu_result_t exp;
        issue_op(op, base, imm, '0, id);
        take_result(1'b1, res);
        exp = '{valid: 1'b1, trans_id: id, result: expect_load(op, base + imm), ex: '0};
        check_result($sformatf("load %s", op.name()), res, exp);
        check_exception("load", res.ex, '0);
    endtask

    task automatic do_misaligned(lsu_op_t op, logic [XLEN-1:0] base, logic [XLEN-1:0] imm,
                                 logic [TRANS_ID_BITS-1:0] id);
        lsu_result_t    res;
        lsu_exception_t exp_ex;
        logic           load_op;
        load_op = (op inside {LB, LBU, LH, LHU, LW});
        mem_req_seen = 1'b0;
        issue_op(op, base, imm, 32'h0000_ffff, id);
        take_result(load_op, res);
        exp_ex = '{cause: load_op ? XLEN'(4) : XLEN'(6), tval: base + imm, valid: 1'b1};
        check_result("misaligned", res, '{valid: 1'b1, trans_id: id, result: '0, ex: '0});
        check_exception("misaligned", res.ex, exp_ex);
        check_flag("memory request on misaligned access", mem_req_seen, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic check_after_reset();
        check_flag("ready after reset", lsu_ready_o, 1'b1);
        check_flag("load result valid after reset", load_result_o.valid, 1'b0);
        check_flag("store result valid after reset", store_result_o.valid, 1'b0);
        check_flag("load request after reset", ld_mem_req_o.req, 1'b0);
        check_flag("store request after reset", st_mem_req_o.req, 1'b0);
    endtask

    task automatic word_store_load();
        // 0x0f8 and 0x10c, from a negative and a positive offset
        do_store(SW, 32'h100, 32'hffff_fff8, 32'h6a09_e667, 3'd1);
        do_store(SW, 32'h100, 32'h0000_000c, 32'hbb67_ae85, 3'd2);
        do_load(LW, 32'h100, 32'hffff_fff8, 3'd3);
        do_load(LW, 32'h100, 32'h0000_000c, 3'd4);
    endtask

    task automatic sub_word_access();
        do_store(SW, 32'h1f0, 32'h10, 32'h1122_3344, 3'd1);
        do_store(SB, 32'h200, 32'h1, 32'hffff_ffa5, 3'd2);
        do_store(SH, 32'h204, 32'hffff_fffe, 32'h1234_9c07, 3'd3);
        for (int lane = 0; lane < 4; lane++) begin
            do_load(LB, 32'h200, lane, TRANS_ID_BITS'(2 * lane));
            do_load(LBU, 32'h200, lane, TRANS_ID_BITS'(2 * lane + 1));
        end
        for (int off = 0; off < 4; off += 2) begin
            do_load(LH, 32'h200, off, TRANS_ID_BITS'(off + 4));
            do_load(LHU, 32'h200, off, TRANS_ID_BITS'(off + 5));
        end
    endtask

    task automatic misaligned_access();
        do_misaligned(LW, 32'h100, 32'h2, 3'd6);
        do_misaligned(SH, 32'h10c, 32'h1, 3'd7);
        do_load(LW, 32'h100, 32'hc, 3'd0);
    endtask

    task automatic back_to_back_under_stalls();
        lsu_result_t first;
        lsu_result_t second;
        long_stall = 1'b1;
        issue_op(LW, 32'h200, '0, '0, 3'd5);
        check_flag("ready while a load waits for grant", lsu_ready_o, 1'b0);
        issue_op(LW, 32'h0f8, '0, '0, 3'd6);
        check_flag("ready with a second load queued", lsu_ready_o, 1'b0);
        take_result(1'b1, first);
        take_result(1'b1, second);
        check_result("first queued load", first,
                     '{valid: 1'b1, trans_id: 3'd5, result: expect_load(LW, 32'h200), ex: '0});
        check_result("second queued load", second,
                     '{valid: 1'b1, trans_id: 3'd6, result: expect_load(LW, 32'h0f8), ex: '0});
        issue_op(SW, 32'h300, '0, 32'h3c6e_f372, 3'd7);
        issue_op(LW, 32'h300, '0, '0, 3'd0);
        take_result(1'b0, first);
        check_result("queued store", first, '{valid: 1'b1, trans_id: 3'd7, result: '0, ex: '0});
        shadow_store(SW, 32'h300, 32'h3c6e_f372);
        take_result(1'b1, second);
        check_result("load after queued store", second,
                     '{valid: 1'b1, trans_id: 3'd0, result: expect_load(LW, 32'h300), ex: '0});
        long_stall = 1'b0;
    endtask

    task automatic flush_pending_load();
        issue_op(LW, 32'h200, '0, '0, 3'd2);
        // response is on the bus, flush before it is taken
        while (!ld_mem_resp_i.rvalid) begin
            @(negedge clk_i);
        end
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        repeat (4) @(negedge clk_i);
        check_flag("load result after flush", ld_results.size() != 0, 1'b0);
        do_load(LW, 32'h200, '0, 3'd3);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", MaxCycles);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        flush_i      = 1'b0;
        lsu_valid_i  = 1'b0;
        fu_data_i    = '0;
        long_stall   = 1'b0;
        mem_req_seen = 1'b0;
        repeat (ResetCycles) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_after_reset();
        word_store_load();
        sub_word_access();
        misaligned_access();
        back_to_back_under_stalls();
        flush_pending_load();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
